// File: source/ifid_pkg.sv
//////////////////////////////
// shared decode constants for the IF/ID stage
// rns opcodes have no entry here and decode as nop
//////////////////////////////
package ifid_pkg;

    // field widths
    localparam int INSTR_W     = 16;
    localparam int OPCODE_W    = 5;
    localparam int REG_ADDR_W  = 3;   // domain flag bit dropped
    localparam int PC_W        = 10;
    localparam int IMM_W       = 8;
    localparam int STACK_DEPTH = 4;   // return addresses held
    localparam int STACK_CNT_W = $clog2(STACK_DEPTH + 1);

    //////////////////////////////
    // opcodes, original encodings
    //////////////////////////////
    localparam logic [OPCODE_W-1:0] OP_NOP    = 5'd0;
    localparam logic [OPCODE_W-1:0] OP_ADD    = 5'd1;
    localparam logic [OPCODE_W-1:0] OP_SUB    = 5'd2;
    localparam logic [OPCODE_W-1:0] OP_AND    = 5'd3;
    localparam logic [OPCODE_W-1:0] OP_OR     = 5'd4;
    localparam logic [OPCODE_W-1:0] OP_NOT    = 5'd5;
    localparam logic [OPCODE_W-1:0] OP_SHL    = 5'd6;
    localparam logic [OPCODE_W-1:0] OP_JMP    = 5'd7;
    localparam logic [OPCODE_W-1:0] OP_RLOAD  = 5'd8;
    localparam logic [OPCODE_W-1:0] OP_RSTORE = 5'd9;
    localparam logic [OPCODE_W-1:0] OP_ANDBIT = 5'd10;
    localparam logic [OPCODE_W-1:0] OP_ORBIT  = 5'd11;
    localparam logic [OPCODE_W-1:0] OP_NOTBIT = 5'd12;
    localparam logic [OPCODE_W-1:0] OP_CMP    = 5'd13;
    localparam logic [OPCODE_W-1:0] OP_JGT    = 5'd14;
    localparam logic [OPCODE_W-1:0] OP_JLT    = 5'd15;
    localparam logic [OPCODE_W-1:0] OP_JEQ    = 5'd16;
    localparam logic [OPCODE_W-1:0] OP_JC     = 5'd17;
    localparam logic [OPCODE_W-1:0] OP_LDI    = 5'd18;
    localparam logic [OPCODE_W-1:0] OP_OUT    = 5'd26;
    localparam logic [OPCODE_W-1:0] OP_IN     = 5'd27;
    localparam logic [OPCODE_W-1:0] OP_CALL   = 5'd30;
    localparam logic [OPCODE_W-1:0] OP_RET    = 5'd31;

    //////////////////////////////
    // control word bit positions
    //////////////////////////////
    localparam int CTRL_W     = 24;
    localparam int C_ADD      = 0;
    localparam int C_OR_L     = 1;    // logical or
    localparam int C_NOT_L    = 2;
    localparam int C_AND_B    = 3;    // bitwise and
    localparam int C_OR_B     = 4;
    localparam int C_NOT_B    = 5;
    localparam int C_AND_L    = 6;
    localparam int C_CARRY_IN = 7;
    localparam int C_OP2_CPL  = 8;    // complement op2, with carry_in gives subtract
    localparam int C_JUMP     = 9;
    localparam int C_COMPARE  = 10;
    localparam int C_SHL      = 11;
    localparam int C_LOGIC    = 12;   // logical or bitwise result select
    localparam int C_STORE    = 13;
    localparam int C_LOAD     = 14;
    localparam int C_WR_REG   = 15;
    localparam int C_JGT      = 16;
    localparam int C_JLT      = 17;
    localparam int C_JEQ      = 18;
    localparam int C_JC       = 19;
    localparam int C_UNCOND   = 20;
    localparam int C_LD_IMM   = 21;
    localparam int C_OUT_OP   = 22;
    localparam int C_IN_OP    = 23;

    // one instruction word, three views
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic [REG_ADDR_W-1:0] rd;
            logic [3:0]            rs2;    // bit 3 is the old domain flag
            logic [3:0]            rs1;
        } r;
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic [REG_ADDR_W-1:0] rd;
            logic [IMM_W-1:0]      imm;    // also the port number for in/out
        } i;
        struct packed {
            logic [OPCODE_W-1:0]   opcode;
            logic                  spare;
            logic [PC_W-1:0]       target;
        } b;
    } instr_t;

endpackage

// File: source/instr_decoder.sv
//////////////////////////////
// combinational opcode decode, no state
// push and pop requests are already gated by squash
//////////////////////////////
module instr_decoder import ifid_pkg::*; (
    input  instr_t                instr,
    input  logic [PC_W-1:0]       pc,
    input  logic                  branch_taken_ex,   // level from execute
    input  logic [PC_W-1:0]       top_addr,          // top of return stack
    input  logic                  empty,
    output logic [CTRL_W-1:0]     ctrl,
    output logic [IMM_W-1:0]      imm,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rs3,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [PC_W-1:0]       next_pc,
    output logic                  squash,
    output logic                  push_req,
    output logic                  pop_req,
    output logic [PC_W-1:0]       push_addr
);

    logic use_rs12;   // op reads rs1 and rs2
    logic use_rs3;    // op reads rd as a source
    logic no_rd;      // rd field is not a destination
    logic is_call;
    logic is_ret;

    //////////////////////////////
    // flag table
    //////////////////////////////
    always_comb
    begin
        ctrl     = '0;
        use_rs12 = 1'b0;
        use_rs3  = 1'b0;
        no_rd    = 1'b0;
        is_call  = 1'b0;
        is_ret   = 1'b0;
        case (instr.r.opcode)
            OP_NOP: ;
            OP_ADD:
            begin
                ctrl[C_ADD]    = 1'b1;
                ctrl[C_WR_REG] = 1'b1;
                use_rs12       = 1'b1;
            end
            OP_SUB, OP_CMP:
            begin
                ctrl[C_ADD]      = 1'b1;
                ctrl[C_CARRY_IN] = 1'b1;   // two's complement subtract
                ctrl[C_OP2_CPL]  = 1'b1;
                ctrl[C_WR_REG]   = (instr.r.opcode == OP_SUB);   // cmp only sets flags
                ctrl[C_COMPARE]  = (instr.r.opcode == OP_CMP);
                use_rs12         = 1'b1;
            end
            OP_AND, OP_OR, OP_NOT, OP_ANDBIT, OP_ORBIT, OP_NOTBIT:
            begin
                ctrl[C_AND_L]  = (instr.r.opcode == OP_AND);
                ctrl[C_OR_L]   = (instr.r.opcode == OP_OR);
                ctrl[C_NOT_L]  = (instr.r.opcode == OP_NOT);
                ctrl[C_AND_B]  = (instr.r.opcode == OP_ANDBIT);
                ctrl[C_OR_B]   = (instr.r.opcode == OP_ORBIT);
                ctrl[C_NOT_B]  = (instr.r.opcode == OP_NOTBIT);
                ctrl[C_LOGIC]  = 1'b1;
                ctrl[C_WR_REG] = 1'b1;
                use_rs12       = 1'b1;
            end
            OP_SHL:
            begin
                ctrl[C_SHL]    = 1'b1;
                ctrl[C_WR_REG] = 1'b1;
                use_rs12       = 1'b1;
            end
            OP_RLOAD:
            begin
                ctrl[C_LOAD]   = 1'b1;
                ctrl[C_WR_REG] = 1'b1;
                use_rs12       = 1'b1;   // rs1/rs2 hold the memory address bytes
            end
            OP_RSTORE:
            begin
                ctrl[C_STORE] = 1'b1;
                use_rs12      = 1'b1;
                use_rs3       = 1'b1;    // rd field is the data source here
                no_rd         = 1'b1;
            end
            OP_JMP, OP_JGT, OP_JLT, OP_JEQ, OP_JC:
            begin
                ctrl[C_JUMP]   = 1'b1;
                ctrl[C_UNCOND] = (instr.r.opcode == OP_JMP);
                ctrl[C_JGT]    = (instr.r.opcode == OP_JGT);
                ctrl[C_JLT]    = (instr.r.opcode == OP_JLT);
                ctrl[C_JEQ]    = (instr.r.opcode == OP_JEQ);
                ctrl[C_JC]     = (instr.r.opcode == OP_JC);
                no_rd          = 1'b1;   // rd bits belong to the target
            end
            OP_LDI:
            begin
                ctrl[C_LD_IMM] = 1'b1;
                ctrl[C_WR_REG] = 1'b1;
            end
            OP_OUT:
            begin
                ctrl[C_OUT_OP] = 1'b1;
                use_rs3        = 1'b1;   // register sent to the port
            end
            OP_IN:
            begin
                ctrl[C_IN_OP]  = 1'b1;
                ctrl[C_WR_REG] = 1'b1;
            end
            OP_CALL:
            begin
                ctrl[C_JUMP]   = 1'b1;   // a jmp that also pushes pc
                ctrl[C_UNCOND] = 1'b1;
                no_rd          = 1'b1;
                is_call        = 1'b1;
            end
            OP_RET:
            begin
                ctrl[C_UNCOND] = 1'b1;
                no_rd          = 1'b1;
                is_ret         = 1'b1;
            end
            default: ;   // rns and unused codes, nop
        endcase
    end

    // operand addresses, zero when not read
    assign rs1 = use_rs12 ? instr.r.rs1[REG_ADDR_W-1:0] : '0;
    assign rs2 = use_rs12 ? instr.r.rs2[REG_ADDR_W-1:0] : '0;
    assign rs3 = use_rs3 ? instr.r.rd : '0;
    assign rd  = no_rd ? '0 : instr.r.rd;
    assign imm = instr.i.imm;

    // return target falls back to 0 on an empty stack
    assign next_pc = is_ret ? (empty ? '0 : top_addr) : instr.b.target;

    assign squash    = branch_taken_ex;
    assign push_req  = is_call && !branch_taken_ex;
    assign pop_req   = is_ret && !branch_taken_ex;
    assign push_addr = pc;   // call returns to its own pc

endmodule

// File: source/call_ret_stack.sv
//////////////////////////////
// return address stack with entry 0 as the top
// a push when full drops the oldest, a pop when empty is ignored
//////////////////////////////
module call_ret_stack import ifid_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            fire,        // accept edge from idex_reg
    input  logic            push_req,
    input  logic            pop_req,
    input  logic [PC_W-1:0] push_addr,
    output logic [PC_W-1:0] top_addr,
    output logic            empty
);

    logic [PC_W-1:0]        entry [STACK_DEPTH];
    logic [STACK_CNT_W-1:0] count;
    logic                   full;

    assign full     = (count == STACK_CNT_W'(STACK_DEPTH));
    assign empty    = (count == '0);
    assign top_addr = entry[0];

    // entries shift on push and pop
    always_ff @(posedge clk)
    begin
        if (fire && push_req)
        begin
            entry[0] <= push_addr;
            for (int k = 1; k < STACK_DEPTH; k++)
            begin
                entry[k] <= entry[k-1];   // last entry falls off when full
            end
        end
        else if (fire && pop_req && !empty)
        begin
            for (int k = 0; k < STACK_DEPTH - 1; k++)
            begin
                entry[k] <= entry[k+1];
            end
        end
    end

    // occupancy count saturates at depth
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count <= '0;
        end
        else if (fire && push_req && !full)
        begin
            count <= count + 1'b1;
        end
        else if (fire && pop_req && !empty)
        begin
            count <= count - 1'b1;
        end
    end

endmodule

// File: source/idex_reg.sv
//////////////////////////////
// single ID/EX register, one entry
// payload loads only on fire and holds while stalled
//////////////////////////////
module idex_reg import ifid_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic                  fire,
    input  logic [CTRL_W-1:0]     ctrl,
    input  logic [IMM_W-1:0]      imm,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [REG_ADDR_W-1:0] rs3,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [PC_W-1:0]       next_pc,
    input  logic [PC_W-1:0]       pc,
    input  logic                  squash,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [CTRL_W-1:0]     out_ctrl,
    output logic [IMM_W-1:0]      out_imm,
    output logic [REG_ADDR_W-1:0] out_rs1,
    output logic [REG_ADDR_W-1:0] out_rs2,
    output logic [REG_ADDR_W-1:0] out_rs3,
    output logic [REG_ADDR_W-1:0] out_rd,
    output logic [PC_W-1:0]       out_next_pc,
    output logic [PC_W-1:0]       out_pc,
    output logic                  out_squash
);

    // free slot, or the held item leaves this edge
    assign in_ready = !out_valid || out_ready;
    assign fire     = in_valid && in_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;   // drains to 0 with no new item
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (fire)
        begin
            out_ctrl    <= ctrl;
            out_imm     <= imm;
            out_rs1     <= rs1;
            out_rs2     <= rs2;
            out_rs3     <= rs3;
            out_rd      <= rd;
            out_next_pc <= next_pc;
            out_pc      <= pc;
            out_squash  <= squash;
        end
    end

endmodule

// File: source/ifid_stage.sv
//////////////////////////////
// instruction decode stage top, one cycle latency
// branch_taken_ex is sampled with the accepted instruction
//////////////////////////////
module ifid_stage import ifid_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  instr_t                in_instr,
    input  logic [PC_W-1:0]       in_pc,
    input  logic                  branch_taken_ex,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [CTRL_W-1:0]     out_ctrl,
    output logic [IMM_W-1:0]      out_imm,
    output logic [REG_ADDR_W-1:0] out_rs1,
    output logic [REG_ADDR_W-1:0] out_rs2,
    output logic [REG_ADDR_W-1:0] out_rs3,
    output logic [REG_ADDR_W-1:0] out_rd,
    output logic [PC_W-1:0]       out_next_pc,
    output logic [PC_W-1:0]       out_pc,
    output logic                  out_squash
);

    // decoder outputs
    logic [CTRL_W-1:0]     dec_ctrl;
    logic [IMM_W-1:0]      dec_imm;
    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    logic [REG_ADDR_W-1:0] dec_rs3;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [PC_W-1:0]       dec_next_pc;
    logic                  dec_squash;
    // stack side
    logic                  push_req;
    logic                  pop_req;
    logic [PC_W-1:0]       push_addr;
    logic [PC_W-1:0]       top_addr;
    logic                  stack_empty;
    logic                  fire;

    instr_decoder dec_i (
        .instr           (in_instr),
        .pc              (in_pc),
        .branch_taken_ex (branch_taken_ex),
        .top_addr        (top_addr),
        .empty           (stack_empty),
        .ctrl            (dec_ctrl),
        .imm             (dec_imm),
        .rs1             (dec_rs1),
        .rs2             (dec_rs2),
        .rs3             (dec_rs3),
        .rd              (dec_rd),
        .next_pc         (dec_next_pc),
        .squash          (dec_squash),
        .push_req        (push_req),
        .pop_req         (pop_req),
        .push_addr       (push_addr)
    );

    call_ret_stack stack_i (
        .clk       (clk),
        .rst       (rst),
        .fire      (fire),        // stack moves only with an accepted instruction
        .push_req  (push_req),
        .pop_req   (pop_req),
        .push_addr (push_addr),
        .top_addr  (top_addr),
        .empty     (stack_empty)
    );

    idex_reg reg_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .fire        (fire),
        .ctrl        (dec_ctrl),
        .imm         (dec_imm),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .rs3         (dec_rs3),
        .rd          (dec_rd),
        .next_pc     (dec_next_pc),
        .pc          (in_pc),
        .squash      (dec_squash),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_ctrl    (out_ctrl),
        .out_imm     (out_imm),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_rs3     (out_rs3),
        .out_rd      (out_rd),
        .out_next_pc (out_next_pc),
        .out_pc      (out_pc),
        .out_squash  (out_squash)
    );

endmodule

// File: tb/ifid_checker.sv
//////////////////////////////
// watches the DUT ports and compares every output transfer
// expected items come from a reference decode and a model return stack
//////////////////////////////
module ifid_checker import ifid_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  instr_t                in_instr,
    input  logic [PC_W-1:0]       in_pc,
    input  logic                  branch_taken_ex,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  logic [CTRL_W-1:0]     out_ctrl,
    input  logic [IMM_W-1:0]      out_imm,
    input  logic [REG_ADDR_W-1:0] out_rs1,
    input  logic [REG_ADDR_W-1:0] out_rs2,
    input  logic [REG_ADDR_W-1:0] out_rs3,
    input  logic [REG_ADDR_W-1:0] out_rd,
    input  logic [PC_W-1:0]       out_next_pc,
    input  logic [PC_W-1:0]       out_pc,
    input  logic                  out_squash,
    output int                    errors,
    output int                    transfers,
    output int                    pending
);
    timeunit 1ns;
    timeprecision 100ps;

    // one output item in DUT port order
    typedef struct packed {
        logic [CTRL_W-1:0]     ctrl;
        logic [IMM_W-1:0]      imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs3;
        logic [REG_ADDR_W-1:0] rd;
        logic [PC_W-1:0]       next_pc;
        logic [PC_W-1:0]       pc;
        logic                  squash;
    } item_t;

    item_t           exp_q [$];
    logic [PC_W-1:0] ret_q [$];      // model stack with the top at index 0
    item_t           held;           // outputs seen at a stalled edge
    logic            stalled = 1'b0;
    logic            fired   = 1'b0;
    logic            rst_d   = 1'b0;
    int              err_n   = 0;
    int              xfer_n  = 0;
    int              pend_n  = 0;

    assign errors    = err_n;
    assign transfers = xfer_n;
    assign pending   = pend_n;

    function automatic logic [CTRL_W-1:0] bit_at(input int pos);
        return CTRL_W'(1) << pos;
    endfunction

    //////////////////////////////
    // reference decode
    //////////////////////////////
    function automatic item_t ref_decode(input instr_t ins, input logic [PC_W-1:0] pc,
                                         input logic bt, input logic [PC_W-1:0] ret_pc);
        item_t               e;
        logic [OPCODE_W-1:0] op;
        logic [CTRL_W-1:0]   sub_bits;
        logic [CTRL_W-1:0]   logic_bits;
        logic                pair;     // reads rs1 and rs2
        logic                src3;     // rd field read as a source
        logic                nodest;   // no register written through rd
        op         = ins.r.opcode;
        sub_bits   = bit_at(C_ADD) | bit_at(C_CARRY_IN) | bit_at(C_OP2_CPL);
        logic_bits = bit_at(C_LOGIC) | bit_at(C_WR_REG);
        e          = '0;
        case (op)
            OP_ADD:    e.ctrl = bit_at(C_ADD) | bit_at(C_WR_REG);
            OP_SUB:    e.ctrl = sub_bits | bit_at(C_WR_REG);
            OP_CMP:    e.ctrl = sub_bits | bit_at(C_COMPARE);   // flags only
            OP_AND:    e.ctrl = logic_bits | bit_at(C_AND_L);
            OP_OR:     e.ctrl = logic_bits | bit_at(C_OR_L);
            OP_NOT:    e.ctrl = logic_bits | bit_at(C_NOT_L);
            OP_ANDBIT: e.ctrl = logic_bits | bit_at(C_AND_B);
            OP_ORBIT:  e.ctrl = logic_bits | bit_at(C_OR_B);
            OP_NOTBIT: e.ctrl = logic_bits | bit_at(C_NOT_B);
            OP_SHL:    e.ctrl = bit_at(C_SHL) | bit_at(C_WR_REG);
            OP_RLOAD:  e.ctrl = bit_at(C_LOAD) | bit_at(C_WR_REG);
            OP_RSTORE: e.ctrl = bit_at(C_STORE);
            OP_JMP:    e.ctrl = bit_at(C_JUMP) | bit_at(C_UNCOND);
            OP_JGT:    e.ctrl = bit_at(C_JUMP) | bit_at(C_JGT);
            OP_JLT:    e.ctrl = bit_at(C_JUMP) | bit_at(C_JLT);
            OP_JEQ:    e.ctrl = bit_at(C_JUMP) | bit_at(C_JEQ);
            OP_JC:     e.ctrl = bit_at(C_JUMP) | bit_at(C_JC);
            OP_LDI:    e.ctrl = bit_at(C_LD_IMM) | bit_at(C_WR_REG);
            OP_OUT:    e.ctrl = bit_at(C_OUT_OP);
            OP_IN:     e.ctrl = bit_at(C_IN_OP) | bit_at(C_WR_REG);
            OP_CALL:   e.ctrl = bit_at(C_JUMP) | bit_at(C_UNCOND);
            OP_RET:    e.ctrl = bit_at(C_UNCOND);
            default:   e.ctrl = '0;   // nop, rns, unused
        endcase
        pair   = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOT, OP_SHL, OP_RLOAD,
                            OP_RSTORE, OP_ANDBIT, OP_ORBIT, OP_NOTBIT, OP_CMP};
        src3   = op inside {OP_RSTORE, OP_OUT};
        nodest = op inside {OP_RSTORE, OP_JMP, OP_JGT, OP_JLT, OP_JEQ, OP_JC,
                            OP_CALL, OP_RET};
        e.rs1     = pair ? ins.r.rs1[REG_ADDR_W-1:0] : '0;   // domain bit dropped
        e.rs2     = pair ? ins.r.rs2[REG_ADDR_W-1:0] : '0;
        e.rs3     = src3 ? ins.r.rd : '0;
        e.rd      = nodest ? '0 : ins.r.rd;
        e.imm     = ins.i.imm;
        e.next_pc = (op == OP_RET) ? ret_pc : ins.b.target;
        e.pc      = pc;
        e.squash  = bt;
        return e;
    endfunction

    task automatic check_field(input string name, input string when,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            err_n++;
            $display("** Error %s %s: expected %h, got %h", name, when, exp, act);
        end
    endtask

    task automatic compare_item(input item_t e, input item_t a, input string when);
        check_field("out_ctrl", when, 32'(e.ctrl), 32'(a.ctrl));
        check_field("out_imm", when, 32'(e.imm), 32'(a.imm));
        check_field("out_rs1", when, 32'(e.rs1), 32'(a.rs1));
        check_field("out_rs2", when, 32'(e.rs2), 32'(a.rs2));
        check_field("out_rs3", when, 32'(e.rs3), 32'(a.rs3));
        check_field("out_rd", when, 32'(e.rd), 32'(a.rd));
        check_field("out_next_pc", when, 32'(e.next_pc), 32'(a.next_pc));
        check_field("out_pc", when, 32'(e.pc), 32'(a.pc));
        check_field("out_squash", when, 32'(e.squash), 32'(a.squash));
    endtask

    //////////////////////////////
    // edge by edge watch
    //////////////////////////////
    always @(posedge clk)
    begin
        item_t           act;
        item_t           e;
        logic [PC_W-1:0] ret_pc;
        act = {out_ctrl, out_imm, out_rs1, out_rs2, out_rs3, out_rd,
               out_next_pc, out_pc, out_squash};   // values before this edge
        if (rst)
        begin
            exp_q.delete();
            ret_q.delete();
            stalled = 1'b0;
            fired   = 1'b0;
        end
        else
        begin
            if (rst_d)   // first edge out of reset
            begin
                check_field("out_valid", "after reset", 32'h0, 32'(out_valid));
                check_field("in_ready", "after reset", 32'h1, 32'(in_ready));
            end
            // only a held item that is not leaving blocks the input
            check_field("in_ready", "at edge", 32'(!(out_valid && !out_ready)), 32'(in_ready));
            if (fired)
            begin
                check_field("out_valid", "one edge after fire", 32'h1, 32'(out_valid));
            end
            if (stalled)
            begin
                check_field("out_valid", "while stalled", 32'h1, 32'(out_valid));
                compare_item(held, act, "held under stall");
            end
            if (out_valid && out_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    err_n++;
                    $display("output transfer with no instruction outstanding, pc %h", out_pc);
                end
                else
                begin
                    e = exp_q.pop_front();
                    compare_item(e, act, "on transfer");
                    xfer_n++;
                end
            end
            stalled = out_valid && !out_ready;
            held    = act;
            fired   = in_valid && in_ready;
            if (fired)
            begin
                ret_pc = (ret_q.size() > 0) ? ret_q[0] : '0;
                exp_q.push_back(ref_decode(in_instr, in_pc, branch_taken_ex, ret_pc));
                if (!branch_taken_ex && in_instr.r.opcode == OP_CALL)
                begin
                    ret_q.push_front(in_pc);
                    if (ret_q.size() > STACK_DEPTH)
                    begin
                        void'(ret_q.pop_back());   // oldest falls off
                    end
                end
                else if (!branch_taken_ex && in_instr.r.opcode == OP_RET && ret_q.size() > 0)
                begin
                    void'(ret_q.pop_front());
                end
            end
        end
        rst_d  = rst;
        pend_n = exp_q.size();
    end

endmodule

// File: tb/tb_ifid.sv
//////////////////////////////
// IF/ID stage testbench, directed stack sequences then random traffic
// inputs change 2 ns after the rising edge, the checker samples on the edge
//////////////////////////////
module tb_ifid import ifid_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAND_COUNT = 400;   // random instructions after the directed part
    localparam int WAIT_LIMIT = 200;   // cycles any single wait may take

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    instr_t                in_instr;
    logic [PC_W-1:0]       in_pc;
    logic                  branch_taken_ex;
    logic                  out_valid;
    logic                  out_ready;
    logic [CTRL_W-1:0]     out_ctrl;
    logic [IMM_W-1:0]      out_imm;
    logic [REG_ADDR_W-1:0] out_rs1;
    logic [REG_ADDR_W-1:0] out_rs2;
    logic [REG_ADDR_W-1:0] out_rs3;
    logic [REG_ADDR_W-1:0] out_rd;
    logic [PC_W-1:0]       out_next_pc;
    logic [PC_W-1:0]       out_pc;
    logic                  out_squash;

    int          seed = 32'h12a8_90e0;
    logic [31:0] rnd;
    logic [16:0] program_q [$];   // {branch_taken_ex, instr}
    int          errors;
    int          transfers;
    int          pending;
    int          sent_n;
    logic        hung;            // some wait ran out

    ifid_stage dut_i (.*);

    ifid_checker chk_i (
        .clk (clk), .rst (rst), .in_valid (in_valid), .in_ready (in_ready),
        .in_instr (in_instr), .in_pc (in_pc), .branch_taken_ex (branch_taken_ex),
        .out_valid (out_valid), .out_ready (out_ready), .out_ctrl (out_ctrl),
        .out_imm (out_imm), .out_rs1 (out_rs1), .out_rs2 (out_rs2), .out_rs3 (out_rs3),
        .out_rd (out_rd), .out_next_pc (out_next_pc), .out_pc (out_pc),
        .out_squash (out_squash), .errors (errors), .transfers (transfers),
        .pending (pending)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // one directed item, random fields around a fixed opcode
    task automatic queue_op(input logic [OPCODE_W-1:0] op, input logic bt);
        instr_t ins;
        rnd = $random(seed);
        ins = rnd[15:0];
        ins.r.opcode = op;
        program_q.push_back({bt, ins});
    endtask

    //////////////////////////////
    // fetch side
    //////////////////////////////
    task automatic send_instr(input instr_t ins, input logic bt);
        int   waited;
        logic done;
        waited          = 0;
        done            = 1'b0;
        in_valid        = 1'b1;
        in_instr        = ins;
        branch_taken_ex = bt;   // held with the instruction until accepted
        while (!done && !hung)
        begin
            rnd       = $random(seed);
            out_ready = (rnd[7:0] < 8'd179);   // about 70 %
            #1;
            done = in_ready;                    // in_valid high, so the next edge fires
            @(posedge clk);
            #2;
            waited++;
            if (!done && waited > WAIT_LIMIT)
            begin
                $display("timeout: instruction at pc %h was never accepted", in_pc);
                hung = 1'b1;
            end
        end
        if (done)
        begin
            sent_n++;
            in_pc = in_pc + 1'b1;   // fetch moves on only after acceptance
            rnd   = $random(seed);
            if (rnd[3:0] < 4'd3)    // idle cycle now and then
            begin
                in_valid  = 1'b0;
                out_ready = (rnd[15:8] < 8'd179);
                @(posedge clk);
                #2;
            end
        end
    endtask

    // let the last items leave the DUT
    task automatic drain_outputs();
        int waited;
        waited    = 0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while ((out_valid || pending != 0) && !hung)
        begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                $display("timeout: outputs did not drain, %0d items still expected", pending);
                hung = 1'b1;
            end
        end
    endtask

    task automatic finish_run();
        $display("sent %0d, transfers %0d, errors %0d, pending %0d, timeout %0d",
                 sent_n, transfers, errors, pending, hung);
        if (errors == 0 && !hung && pending == 0 && transfers == sent_n)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial
    begin
        logic [16:0] item;
        instr_t      ins;
        rst             = 1'b1;
        in_valid        = 1'b0;
        in_instr        = '0;
        in_pc           = 10'h040;   // nonzero, so a return to 0 stands out
        branch_taken_ex = 1'b0;
        out_ready       = 1'b0;
        hung            = 1'b0;
        sent_n          = 0;

        queue_op(OP_RET, 1'b0);                  // return on an empty stack
        for (int op = 0; op < 32; op++)
        begin
            queue_op(5'(op), 1'b0);              // every opcode, rns and unused too
        end
        repeat (5) queue_op(OP_CALL, 1'b0);      // fifth push loses the oldest
        repeat (5) queue_op(OP_RET, 1'b0);
        queue_op(OP_CALL, 1'b0);
        queue_op(OP_CALL, 1'b1);                 // squashed, no push
        queue_op(OP_RET, 1'b1);                  // squashed, no pop
        queue_op(OP_RET, 1'b0);
        queue_op(OP_RET, 1'b0);                  // empty again

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        while (program_q.size() > 0 && !hung)
        begin
            item = program_q.pop_front();
            send_instr(item[15:0], item[16]);
        end
        for (int n = 0; n < RAND_COUNT && !hung; n++)
        begin
            rnd = $random(seed);
            ins = rnd[15:0];
            if (rnd[19:17] == 3'd0)
            begin
                ins.r.opcode = OP_CALL;   // extra stack traffic
            end
            else if (rnd[19:17] == 3'd1)
            begin
                ins.r.opcode = OP_RET;
            end
            send_instr(ins, (rnd[27:20] < 8'd26));   // taken branch about 10 %
        end
        drain_outputs();
        finish_run();
    end

endmodule

// File: project.f
source/ifid_pkg.sv
source/instr_decoder.sv
source/call_ret_stack.sv
source/idex_reg.sv
source/ifid_stage.sv
tb/ifid_checker.sv
tb/tb_ifid.sv

// File: run.sh
#!/bin/sh
# build and run the IF/ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f project.f --top-module tb_ifid -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_ifid)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
